//--- design/tcm_cfg.svh
// tcm size configuration
`ifndef TCM_CFG_SVH
`define TCM_CFG_SVH

// memory geometry shared by every tcm block
// the word index width follows from depth, see tcm_mem_pkg

// number of words in the array
`define TCM_DEPTH 1024

// data word width in bits
`define TCM_DW 32

// byte lanes per word, one mask bit each
`define TCM_MW 4

// byte address width seen by the requesters
// 10 index bits plus 2 lane offset bits
`define TCM_AW 12

// read path x handling
// 1 maps unknown read bits to zero in simulation
// 0 passes the raw array word through
`define TCM_FORCE_X2ZERO 0

`endif

//--- design/tcm_mem_pkg.sv
// tcm memory side types
`include "tcm_cfg.svh"

package tcm_mem_pkg;

  // word index width, from the array depth
  localparam int TCM_IW = $clog2(`TCM_DEPTH);

  // one stored word
  typedef logic [`TCM_DW-1:0] tcm_word_t;

  // one bit per byte lane
  typedef logic [`TCM_MW-1:0] tcm_mask_t;

  // word address into the array
  typedef logic [TCM_IW-1:0] tcm_index_t;

  // per-port command into the dual ram
  // index is valid on every cycle, loads use it too
  // wdata already has the bytes placed in their lanes
  typedef struct packed {
    // write strobe, only for valid aligned stores
    logic       we;
    // lanes to write
    tcm_mask_t  wem;
    // target word
    tcm_index_t index;
    // lane-placed store data
    tcm_word_t  wdata;
  } tcm_mem_cmd_t;

endpackage

//--- design/tcm_access_pkg.sv
// tcm access side types
`include "tcm_cfg.svh"

package tcm_access_pkg;

  // byte address as the requester sees it
  typedef logic [`TCM_AW-1:0] tcm_addr_t;

  // access opcodes
  // loads first, then stores
  typedef enum logic [2:0] {
    // signed byte load
    op_lb,
    // unsigned byte load
    op_lbu,
    // signed halfword load
    op_lh,
    // unsigned halfword load
    op_lhu,
    // word load
    op_lw,
    // byte store
    op_sb,
    // halfword store
    op_sh,
    // word store
    op_sw
  } tcm_op_e;

  // one-cycle request strobe from a port
  typedef struct packed {
    logic                valid;
    tcm_op_e             op;
    tcm_addr_t           addr;
    // store value sits in the low bits
    logic [`TCM_DW-1:0]  wdata;
  } tcm_req_t;

  // one-cycle response pulse back to the port
  typedef struct packed {
    logic                valid;
    // misaligned request
    logic                err;
    // extended load result, zero for stores
    logic [`TCM_DW-1:0]  rdata;
  } tcm_rsp_t;

endpackage

//--- design/tcm_req_decode.sv
// tcm request decoder
`timescale 1ns/1ps
`include "tcm_cfg.svh"

module tcm_req_decode (
  input  tcm_access_pkg::tcm_req_t  req,
  input  logic                      en,
  output tcm_mem_pkg::tcm_mem_cmd_t cmd,
  output tcm_access_pkg::tcm_op_e   op_q_src,
  output logic [1:0]                offset,
  output logic                      misaligned
);
  import tcm_mem_pkg::*;
  import tcm_access_pkg::*;

  logic      is_store;
  logic      size_half;
  logic      size_word;
  tcm_mask_t lane_mask;
  tcm_word_t lane_data;

  // opcode to size and direction
  always_comb begin
    is_store  = 1'b0;
    size_half = 1'b0;
    size_word = 1'b0;
    case (req.op)
      op_lh, op_lhu: size_half = 1'b1;
      op_lw:         size_word = 1'b1;
      op_sb:         is_store  = 1'b1;
      op_sh: begin
        is_store  = 1'b1;
        size_half = 1'b1;
      end
      op_sw: begin
        is_store  = 1'b1;
        size_word = 1'b1;
      end
      default: ;
    endcase
  end

  // byte lane within the word
  assign offset = req.addr[1:0];

  // halfword needs bit 0 clear, word needs both clear
  assign misaligned = (size_half & offset[0]) | (size_word & (|offset));

  // lane mask and replicated store data
  always_comb begin
    if (size_word) begin
      lane_mask = '1;
      lane_data = req.wdata;
    end else if (size_half) begin
      // upper or lower half of the word
      lane_mask = offset[1] ? 4'b1100 : 4'b0011;
      lane_data = {2{req.wdata[15:0]}};
    end else begin
      lane_mask = tcm_mask_t'(1) << offset;
      lane_data = {4{req.wdata[7:0]}};
    end
    // no lanes for loads or bad alignment
    if (misaligned || !is_store) begin
      lane_mask = '0;
    end
  end

  // command into the ram, index always follows the address
  assign cmd.we    = en & req.valid & is_store & ~misaligned;
  assign cmd.wem   = lane_mask;
  assign cmd.index = req.addr[`TCM_AW-1:2];
  assign cmd.wdata = lane_data;

  // forwarded to the load aligner
  assign op_q_src = req.op;

endmodule

//--- design/tcm_dual_ram.sv
// tcm dual-port word memory
`timescale 1ns/1ps
`include "tcm_cfg.svh"

module tcm_dual_ram (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      en,
  input  tcm_mem_pkg::tcm_mem_cmd_t cmd_a,
  input  tcm_mem_pkg::tcm_mem_cmd_t cmd_b,
  output tcm_mem_pkg::tcm_word_t    rdata_a,
  output tcm_mem_pkg::tcm_word_t    rdata_b
);
  import tcm_mem_pkg::*;

  tcm_word_t  mem [`TCM_DEPTH];
  tcm_mask_t  wen_a;
  tcm_mask_t  wen_b;
  logic       same_index;
  tcm_index_t index_a_q;
  tcm_index_t index_b_q;
  tcm_word_t  pre_a;
  tcm_word_t  pre_b;

  // array starts cleared in simulation
  initial begin
    for (int k = 0; k < `TCM_DEPTH; k++) begin
      mem[k] = '0;
    end
  end

  // lane enables, both gated by the common enable
  assign wen_a = {`TCM_MW{en & cmd_a.we}} & cmd_a.wem;

  // port a owns a lane when both hit the same word
  assign same_index = (cmd_a.index == cmd_b.index);
  assign wen_b = {`TCM_MW{en & cmd_b.we}} & cmd_b.wem & ~(wen_a & {`TCM_MW{same_index}});

  // lane writes
  // different words can take both ports in one edge
  always @(posedge clk) begin
    for (int i = 0; i < `TCM_MW; i++) begin
      if (wen_a[i]) begin
        mem[cmd_a.index][8*i +: 8] <= cmd_a.wdata[8*i +: 8];
      end
      if (wen_b[i]) begin
        mem[cmd_b.index][8*i +: 8] <= cmd_b.wdata[8*i +: 8];
      end
    end
  end

  // registered read indices
  // loaded whenever enabled, stores included
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      index_a_q <= '0;
      index_b_q <= '0;
    end else if (en) begin
      index_a_q <= cmd_a.index;
      index_b_q <= cmd_b.index;
    end
  end

  // read after the edge, so writes of that edge show up
  assign pre_a = mem[index_a_q];
  assign pre_b = mem[index_b_q];

  // optional cleanup of unknown read bits
  generate
    if (`TCM_FORCE_X2ZERO == 1) begin : g_x2zero
      always_comb begin
        for (int i = 0; i < `TCM_DW; i++) begin
          // only a clean one stays one
          rdata_a[i] = (pre_a[i] === 1'b1) ? 1'b1 : 1'b0;
          rdata_b[i] = (pre_b[i] === 1'b1) ? 1'b1 : 1'b0;
        end
      end
    end else begin : g_raw
      assign rdata_a = pre_a;
      assign rdata_b = pre_b;
    end
  endgenerate

endmodule

//--- design/tcm_load_align.sv
// tcm load result aligner
`timescale 1ns/1ps

module tcm_load_align (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     accept,
  input  tcm_access_pkg::tcm_op_e  op,
  input  logic [1:0]               offset,
  input  logic                     misaligned,
  input  tcm_mem_pkg::tcm_word_t   word,
  output tcm_access_pkg::tcm_rsp_t rsp
);
  import tcm_access_pkg::*;

  // one respond cycle per accepted request
  typedef enum logic {
    st_idle,
    st_respond
  } state_e;

  state_e      state_q;
  tcm_op_e     op_q;
  logic [1:0]  offset_q;
  logic        err_q;
  logic        respond;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // back to back accepts keep it in respond
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= st_idle;
      err_q   <= 1'b0;
    end else begin
      state_q <= accept ? st_respond : st_idle;
      if (accept) begin
        err_q <= misaligned;
      end
    end
  end

  // access details for the respond cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q     <= op;
      offset_q <= offset;
    end
  end

  assign respond = (state_q == st_respond);

  // byte and halfword at the stored offset
  assign byte_sel = word[8*offset_q +: 8];
  assign half_sel = word[16*offset_q[1] +: 16];

  // response pulse
  // word arrives this cycle from the registered read index
  always_comb begin
    rsp.valid = respond;
    rsp.err   = respond & err_q;
    rsp.rdata = '0;
    if (respond && !err_q) begin
      case (op_q)
        op_lb:   rsp.rdata = {{24{byte_sel[7]}}, byte_sel};
        op_lbu:  rsp.rdata = {24'd0, byte_sel};
        op_lh:   rsp.rdata = {{16{half_sel[15]}}, half_sel};
        op_lhu:  rsp.rdata = {16'd0, half_sel};
        op_lw:   rsp.rdata = word;
        // stores answer with zero data
        default: rsp.rdata = '0;
      endcase
    end
  end

endmodule

//--- design/tcm_dual_port.sv
// tcm dual-port data memory top
`timescale 1ns/1ps

module tcm_dual_port (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     en,
  input  tcm_access_pkg::tcm_req_t req_a,
  input  tcm_access_pkg::tcm_req_t req_b,
  output tcm_access_pkg::tcm_rsp_t rsp_a,
  output tcm_access_pkg::tcm_rsp_t rsp_b
);
  import tcm_mem_pkg::*;
  import tcm_access_pkg::*;

  tcm_mem_cmd_t cmd_a;
  tcm_mem_cmd_t cmd_b;
  tcm_word_t    word_a;
  tcm_word_t    word_b;
  tcm_op_e      op_a;
  tcm_op_e      op_b;
  logic [1:0]   offset_a;
  logic [1:0]   offset_b;
  logic         misaligned_a;
  logic         misaligned_b;
  logic         accept_a;
  logic         accept_b;

  // a request only counts with the common enable
  assign accept_a = en & req_a.valid;
  assign accept_b = en & req_b.valid;

  // port a, higher write priority
  tcm_req_decode u_decode_a (
    .req        (req_a),
    .en         (en),
    .cmd        (cmd_a),
    .op_q_src   (op_a),
    .offset     (offset_a),
    .misaligned (misaligned_a)
  );

  // port b
  tcm_req_decode u_decode_b (
    .req        (req_b),
    .en         (en),
    .cmd        (cmd_b),
    .op_q_src   (op_b),
    .offset     (offset_b),
    .misaligned (misaligned_b)
  );

  // shared word array
  tcm_dual_ram u_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (en),
    .cmd_a   (cmd_a),
    .cmd_b   (cmd_b),
    .rdata_a (word_a),
    .rdata_b (word_b)
  );

  // responses, one cycle after the accepting edge
  tcm_load_align u_align_a (
    .clk        (clk),
    .rst_n      (rst_n),
    .accept     (accept_a),
    .op         (op_a),
    .offset     (offset_a),
    .misaligned (misaligned_a),
    .word       (word_a),
    .rsp        (rsp_a)
  );

  tcm_load_align u_align_b (
    .clk        (clk),
    .rst_n      (rst_n),
    .accept     (accept_b),
    .op         (op_b),
    .offset     (offset_b),
    .misaligned (misaligned_b),
    .word       (word_b),
    .rsp        (rsp_b)
  );

endmodule

//--- test/tcm_ref_model.svh
// tcm reference model
`ifndef TCM_REF_MODEL_SVH
`define TCM_REF_MODEL_SVH

// shadow copy of the word array
tcm_word_t ref_mem [`TCM_DEPTH];

// access size in bytes
function automatic int ref_size(tcm_op_e op);
  case (op)
    op_lb, op_lbu, op_sb: return 1;
    op_lh, op_lhu, op_sh: return 2;
    default: return 4;
  endcase
endfunction

function automatic logic ref_is_store(tcm_op_e op);
  return (op == op_sb) || (op == op_sh) || (op == op_sw);
endfunction

// offset has to be a multiple of the size
function automatic logic ref_misaligned(tcm_op_e op, logic [1:0] offset);
  return (int'(offset) % ref_size(op)) != 0;
endfunction

// little endian placement
// lanes from offset upward take the value, lowest byte first
function automatic tcm_word_t ref_store(tcm_word_t word, tcm_op_e op, logic [1:0] offset,
                                       tcm_word_t wdata);
  tcm_word_t merged;
  int        k;
  merged = word;
  for (int i = 0; i < `TCM_MW; i++) begin
    k = i - int'(offset);
    if (k >= 0 && k < ref_size(op)) begin
      merged[8*i +: 8] = wdata[8*k +: 8];
    end
  end
  return merged;
endfunction

// load value taken from the offset and extended by opcode
function automatic tcm_word_t ref_load(tcm_word_t word, tcm_op_e op, logic [1:0] offset);
  tcm_word_t shifted;
  shifted = word >> (8 * offset);
  case (op)
    op_lb:   return {{24{shifted[7]}}, shifted[7:0]};
    op_lbu:  return {24'd0, shifted[7:0]};
    op_lh:   return {{16{shifted[15]}}, shifted[15:0]};
    op_lhu:  return {16'd0, shifted[15:0]};
    op_lw:   return word;
    default: return '0;
  endcase
endfunction

`endif

//--- test/tcm_tb.sv
// tcm dual-port testbench
`timescale 1ns/1ps
`include "tcm_cfg.svh"

module tcm_tb;
  import tcm_mem_pkg::*;
  import tcm_access_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int N_RAND = 200;
  // reset, directed tests and random traffic, in cycles
  localparam int N_CYCLES = 8 + 100 + N_RAND;
  localparam tcm_req_t IDLE_REQ = '0;

  logic     clk;
  logic     rst_n;
  logic     en;
  tcm_req_t req_a;
  tcm_req_t req_b;
  tcm_rsp_t rsp_a;
  tcm_rsp_t rsp_b;
  // expected responses for the cycle after the last edge
  tcm_rsp_t exp_a;
  tcm_rsp_t exp_b;
  logic     armed;
  int       seed;
  int       errors;
  int       checks;
  int       tests;
  int       test_errors;

  // store sizes and offsets for the read-back test
  tcm_op_e    store_ops [3] = '{op_sw, op_sh, op_sb};
  logic [1:0] store_offs [3] = '{2'd0, 2'd2, 2'd3};

  `include "tcm_ref_model.svh"

  tcm_dual_port dut (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .req_a (req_a),
    .req_b (req_b),
    .rsp_a (rsp_a),
    .rsp_b (rsp_b)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // valid and err flags
  task automatic check_rsp(string name, tcm_rsp_t got, tcm_rsp_t exp);
    checks++;
    if (got.valid !== exp.valid || got.err !== exp.err) begin
      errors++;
      $display("ERROR %0t %s: got valid=%b err=%b, expected valid=%b err=%b",
               $time, name, got.valid, got.err, exp.valid, exp.err);
    end
  endtask

  task automatic check_word(string name, tcm_word_t got, tcm_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // expected response of one port, after this edge's stores
  function automatic tcm_rsp_t expect_rsp(logic acc, tcm_req_t req);
    tcm_rsp_t r;
    r = '0;
    if (acc) begin
      r.valid = 1'b1;
      r.err   = ref_misaligned(req.op, req.addr[1:0]);
      if (!r.err && !ref_is_store(req.op)) begin
        r.rdata = ref_load(ref_mem[req.addr[`TCM_AW-1:2]], req.op, req.addr[1:0]);
      end
    end
    return r;
  endfunction

  task automatic apply_store(tcm_req_t req);
    tcm_index_t idx;
    idx = req.addr[`TCM_AW-1:2];
    if (ref_is_store(req.op) && !ref_misaligned(req.op, req.addr[1:0])) begin
      ref_mem[idx] = ref_store(ref_mem[idx], req.op, req.addr[1:0], req.wdata);
    end
  endtask

  // model update at each edge
  // port b first so port a overwrites shared lanes
  always @(posedge clk) begin : predict
    logic acc_a;
    logic acc_b;
    acc_a = rst_n & en & req_a.valid;
    acc_b = rst_n & en & req_b.valid;
    if (acc_b) apply_store(req_b);
    if (acc_a) apply_store(req_a);
    exp_a = expect_rsp(acc_a, req_a);
    exp_b = expect_rsp(acc_b, req_b);
    armed = rst_n;
  end

  // compare mid cycle, outputs settled
  always @(negedge clk) begin
    if (armed) begin
      check_rsp("rsp_a", rsp_a, exp_a);
      check_word("rsp_a.rdata", rsp_a.rdata, exp_a.rdata);
      check_rsp("rsp_b", rsp_b, exp_b);
      check_word("rsp_b.rdata", rsp_b.rdata, exp_b.rdata);
    end
  end

  function automatic tcm_req_t make_req(tcm_op_e op, tcm_addr_t addr, tcm_word_t wdata);
    tcm_req_t r;
    r.valid = 1'b1;
    r.op    = op;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  // small window so the ports collide often
  function automatic tcm_req_t random_req();
    tcm_req_t    r;
    logic [31:0] v;
    v       = $random(seed);
    r.valid = v[0] | v[1];
    r.op    = tcm_op_e'(v[4:2]);
    r.addr  = 12'h600 | tcm_addr_t'(v[13:8]);
    r.wdata = $random(seed);
    return r;
  endfunction

  // inputs change just after the edge
  task automatic drive(tcm_req_t a, tcm_req_t b, logic e);
    @(posedge clk);
    #2;
    req_a = a;
    req_b = b;
    en    = e;
  endtask

  // drain the last response, then report
  task automatic end_test(string name);
    drive(IDLE_REQ, IDLE_REQ, 1'b1);
    drive(IDLE_REQ, IDLE_REQ, 1'b1);
    tests++;
    if (errors == test_errors) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin : stimulus
    tcm_req_t ra;
    tcm_req_t rb;
    logic     re;
    seed        = 32'h97a44eda;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    test_errors = 0;
    armed       = 1'b0;
    rst_n       = 1'b0;
    en          = 1'b0;
    req_a       = IDLE_REQ;
    req_b       = IDLE_REQ;
    for (int k = 0; k < `TCM_DEPTH; k++) begin
      ref_mem[k] = '0;
    end
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // quiet ports, then a word load of address 0
    repeat (3) drive(IDLE_REQ, IDLE_REQ, 1'b1);
    drive(make_req(op_lw, 12'h000, '0), make_req(op_lw, 12'h000, '0), 1'b1);
    end_test("reset and idle");

    // store on a, every load size and offset on b
    for (int s = 0; s < 3; s++) begin
      drive(make_req(store_ops[s], tcm_addr_t'(12'h100 + store_offs[s]),
                     $random(seed) | 32'h8080_8080), IDLE_REQ, 1'b1);
      for (int l = 0; l < 5; l++) begin
        for (int o = 0; o < 4; o++) begin
          drive(IDLE_REQ, make_req(tcm_op_e'(l), tcm_addr_t'(12'h100 + o), '0), 1'b1);
        end
      end
    end
    end_test("store sizes and load extension");

    // same word from both ports, a owns the overlap
    drive(make_req(op_sh, 12'h300, 32'h0000_a1a2), make_req(op_sw, 12'h300, 32'hb1b2_b3b4), 1'b1);
    drive(make_req(op_sb, 12'h301, 32'h0000_00c1), make_req(op_sh, 12'h300, 32'h0000_d1d2), 1'b1);
    drive(make_req(op_sw, 12'h304, 32'h1122_3344), make_req(op_sb, 12'h307, 32'h0000_0099), 1'b1);
    drive(make_req(op_lw, 12'h300, '0), make_req(op_lw, 12'h304, '0), 1'b1);
    check_word("model word 0x300", ref_mem[10'h0c0], 32'hb1b2_c1d2);
    end_test("write collision");

    // store and load of one word at the same edge
    drive(make_req(op_sw, 12'h400, 32'hcafe_0123), make_req(op_lw, 12'h400, '0), 1'b1);
    drive(make_req(op_lhu, 12'h402, '0), make_req(op_sh, 12'h402, 32'h0000_8765), 1'b1);
    drive(make_req(op_lb, 12'h401, '0), make_req(op_sb, 12'h401, 32'h0000_00f0), 1'b1);
    end_test("write-first read");

    // misaligned requests write nothing
    drive(make_req(op_sw, 12'h500, 32'h0102_0304), IDLE_REQ, 1'b1);
    drive(make_req(op_sh, 12'h501, 32'h0000_ffff), make_req(op_sw, 12'h502, 32'hdead_beef), 1'b1);
    drive(make_req(op_sw, 12'h503, 32'h5555_aaaa), make_req(op_sh, 12'h503, 32'h0000_7777), 1'b1);
    drive(make_req(op_lh, 12'h503, '0), make_req(op_lw, 12'h501, '0), 1'b1);
    drive(make_req(op_lw, 12'h500, '0), make_req(op_lw, 12'h500, '0), 1'b1);
    check_word("model word 0x500", ref_mem[10'h140], 32'h0102_0304);
    end_test("misaligned access");

    // random traffic, en low about one cycle in four
    for (int i = 0; i < N_RAND; i++) begin
      ra = random_req();
      rb = random_req();
      re = (($random(seed) & 3) != 0);
      drive(ra, rb, re);
    end
    end_test("random traffic");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // run limit from the cycle count of all tests
  initial begin
    #(CLK_PERIOD * (N_CYCLES + 100));
    $display("timeout: the tests did not finish in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- src.f
+incdir+design
+incdir+test
design/tcm_mem_pkg.sv
design/tcm_access_pkg.sv
design/tcm_req_decode.sv
design/tcm_dual_ram.sv
design/tcm_load_align.sv
design/tcm_dual_port.sv
test/tcm_tb.sv
